// File: compile.f
+incdir+design
design/scaler_pkg.sv
design/pixel_memory.sv
design/quad_fetch.sv
design/quad_fifo.sv
design/bilinear_write.sv
design/scaler_top.sv
tb/tb_clock.sv
tb/scaler_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the scaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f --top-module scaler_tb -o scaler_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/scaler_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: tb/scaler_tb.sv
// Scaler testbench
// Loads random images through the external port, runs one pass per table entry
// and checks the output image and counters against a bilinear reference model

`include "scaler_params.svh"

module scaler_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES = 5;

    logic               clk;
    logic               rst;
    logic               start;
    scaler_pkg::dim_t   in_width;
    scaler_pkg::dim_t   in_height;
    scaler_pkg::scale_t scale;
    logic               ext_write;
    logic               ext_read;
    scaler_pkg::addr_t  ext_addr;
    scaler_pkg::pixel_t ext_wdata;
    scaler_pkg::pixel_t ext_rdata;
    logic               busy;
    logic               ready;
    scaler_pkg::count_t op_count;
    scaler_pkg::count_t read_count;
    scaler_pkg::count_t write_count;
    scaler_pkg::count_t ready_pulses;
    integer             seed = 32'h77a4;
    int                 src_img [0:1023];

    // ==================================================
    // Test table
    // ==================================================
    // Scale port is 8 bits wide, so 255 stands in for unity
    string              case_name [NUM_CASES] = '{"near_identity", "halve",
                                                  "three_quarter", "odd_scale", "zero_scale"};
    scaler_pkg::dim_t   case_width [NUM_CASES] = '{8'd8, 8'd16, 8'd10, 8'd32, 8'd6};
    scaler_pkg::dim_t   case_height [NUM_CASES] = '{8'd8, 8'd12, 8'd10, 8'd20, 8'd5};
    scaler_pkg::scale_t case_scale [NUM_CASES] = '{8'd255, 8'd128, 8'd192, 8'd77, 8'd0};

    tb_clock u_clock (.clk(clk), .rst(rst));

    scaler_top dut (
        .clk(clk), .rst(rst), .start(start),
        .in_width(in_width), .in_height(in_height), .scale(scale),
        .ext_write(ext_write), .ext_read(ext_read),
        .ext_addr(ext_addr), .ext_wdata(ext_wdata), .ext_rdata(ext_rdata),
        .busy(busy), .ready(ready),
        .op_count(op_count), .read_count(read_count), .write_count(write_count)
    );

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_pulses <= '0;
        end else if (ready) begin
            ready_pulses <= ready_pulses + 32'd1;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string test, input string item,
                               input scaler_pkg::pixel_t exp, input scaler_pkg::pixel_t act);
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h", test, item, exp, act);
            abort_run("Pixel value differs from the reference");
        end
    endtask

    task automatic check_count(input string test, input string item,
                               input scaler_pkg::count_t exp, input scaler_pkg::count_t act);
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected %0d, actual %0d", test, item, exp, act);
            abort_run("Counter value differs from the reference");
        end
    endtask

    task automatic check_flag(input string test, input string item,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected %b, actual %b", test, item, exp, act);
            abort_run("Status flag differs from the reference");
        end
    endtask

    // One cycle on the external port
    task automatic drive_ext(input logic wr, input logic rd, input int addr,
                             input scaler_pkg::pixel_t data);
        @(posedge clk);
        ext_write <= wr;
        ext_read  <= rd;
        ext_addr  <= scaler_pkg::addr_t'(addr);
        ext_wdata <= data;
    endtask

    task automatic read_byte(input int addr, output scaler_pkg::pixel_t data);
        drive_ext(1'b0, 1'b1, addr, 8'd0);
        drive_ext(1'b0, 1'b0, addr, 8'd0);
        @(negedge clk);
        data = ext_rdata;
    endtask

    function automatic int out_pixels(input int idx);
        int ow;
        int oh;
        ow = (int'(case_width[idx]) * int'(case_scale[idx])) >> 8;
        oh = (int'(case_height[idx]) * int'(case_scale[idx])) >> 8;
        return ow * oh;
    endfunction

    // Bilinear rule in Q8.8 with clamped right and bottom neighbours
    function automatic scaler_pkg::pixel_t model_pixel(input int x, input int y,
                                                      input int w, input int h, input int s);
        int inv;
        int mx;
        int my;
        int x0;
        int x1;
        int y0;
        int y1;
        int fx;
        int fy;
        int top;
        int bot;
        inv = (s == 0) ? 256 : 65536 / s;
        mx  = x * inv;
        my  = y * inv;
        x0  = (mx >> 8) & 255;
        y0  = (my >> 8) & 255;
        fx  = mx & 255;
        fy  = my & 255;
        x1  = (x0 >= w - 1) ? w - 1 : x0 + 1;
        y1  = (y0 >= h - 1) ? h - 1 : y0 + 1;
        top = src_img[y0 * w + x0] * (256 - fx) + src_img[y0 * w + x1] * fx;
        bot = src_img[y1 * w + x0] * (256 - fx) + src_img[y1 * w + x1] * fx;
        return scaler_pkg::pixel_t'((top * (256 - fy) + bot * fy) >> 16);
    endfunction

    task automatic run_pass(input int idx);
        logic seen;
        seen = 1'b0;
        @(posedge clk);
        start     <= 1'b1;
        in_width  <= case_width[idx];
        in_height <= case_height[idx];
        scale     <= case_scale[idx];
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag(case_name[idx], "busy after start", 1'b1, busy);
        while (!seen) begin
            @(negedge clk);
            if (ready) begin
                seen = 1'b1;
            end else begin
                check_flag(case_name[idx], "busy during pass", 1'b1, busy);
            end
        end
        check_flag(case_name[idx], "busy at ready", 1'b0, busy);
        @(negedge clk);
        check_flag(case_name[idx], "ready pulse width", 1'b0, ready);
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += 200 * out_pixels(i)
                   + 100 * int'(case_width[i]) * int'(case_height[i]);
        end
        repeat (limit) @(posedge clk);
        abort_run("Timed out waiting for ready");
    end

    initial begin
        int w;
        int h;
        int s;
        int ow;
        int oh;
        int npix;
        int nsrc;
        scaler_pkg::count_t op0;
        scaler_pkg::count_t rd0;
        scaler_pkg::count_t wr0;
        scaler_pkg::pixel_t value;
        scaler_pkg::pixel_t got;
        logic [31:0]        rnd;
        start     = 1'b0;
        in_width  = '0;
        in_height = '0;
        scale     = '0;
        ext_write = 1'b0;
        ext_read  = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "ready", 1'b0, ready);
        check_count("reset", "op_count", 32'd0, op_count);
        check_count("reset", "read_count", 32'd0, read_count);
        check_count("reset", "write_count", 32'd0, write_count);

        for (int t = 0; t < NUM_CASES; t++) begin
            w    = int'(case_width[t]);
            h    = int'(case_height[t]);
            s    = int'(case_scale[t]);
            ow   = (w * s) >> 8;
            oh   = (h * s) >> 8;
            npix = ow * oh;
            nsrc = w * h;
            op0  = op_count;
            rd0  = read_count;
            wr0  = write_count;

            // Load the source image, reading each byte straight back
            for (int a = 0; a < nsrc; a++) begin
                rnd = $random(seed);
                value = rnd[7:0];
                src_img[a] = int'(value);
                drive_ext(1'b1, 1'b0, a, value);
                read_byte(a, got);
                check_pixel(case_name[t], $sformatf("source byte %0d", a), value, got);
            end

            run_pass(t);

            for (int y = 0; y < oh; y++) begin
                for (int x = 0; x < ow; x++) begin
                    read_byte(`SCALER_OUT_BASE + y * ow + x, got);
                    check_pixel(case_name[t], $sformatf("output (%0d,%0d)", x, y),
                                model_pixel(x, y, w, h, s), got);
                end
            end

            check_count(case_name[t], "op_count",
                        op0 + scaler_pkg::count_t'(`SCALER_OPS_PER_PIXEL * npix), op_count);
            check_count(case_name[t], "write_count",
                        wr0 + scaler_pkg::count_t'(npix + nsrc), write_count);
            check_count(case_name[t], "read_count",
                        rd0 + scaler_pkg::count_t'(5 * npix + nsrc), read_count);
            check_count(case_name[t], "ready pulses",
                        scaler_pkg::count_t'(t + 1), ready_pulses);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset source
// 4 ns clock, reset held high for the first two rising edges

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: design/scaler_top.sv
// Bilinear scaler top level
// Latches the pass settings, sizes the output and runs start/ready around
// the fetch, FIFO and interpolation blocks sharing one memory

module scaler_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  scaler_pkg::dim_t   in_width,
    input  scaler_pkg::dim_t   in_height,
    input  scaler_pkg::scale_t scale,
    input  logic               ext_write,
    input  logic               ext_read,
    input  scaler_pkg::addr_t  ext_addr,
    input  scaler_pkg::pixel_t ext_wdata,
    output scaler_pkg::pixel_t ext_rdata,
    output logic               busy,
    output logic               ready,
    output scaler_pkg::count_t op_count,
    output scaler_pkg::count_t read_count,
    output scaler_pkg::count_t write_count
);

    scaler_pkg::dim_t   src_width;
    scaler_pkg::dim_t   src_height;
    scaler_pkg::scale_t scale_q;
    scaler_pkg::dim_t   out_width;
    scaler_pkg::dim_t   out_height;
    logic [15:0]        w_prod;
    logic [15:0]        h_prod;
    logic [15:0]        pix_total;
    logic [15:0]        wr_cnt;
    logic [15:0]        wr_cnt_next;
    logic               run;
    logic               accept;
    logic               finish;

    logic               rd_req;
    scaler_pkg::addr_t  rd_addr;
    logic               rd_grant;
    scaler_pkg::pixel_t rdata;
    logic               wr_req;
    scaler_pkg::addr_t  wr_addr;
    scaler_pkg::pixel_t wr_data;
    logic               wr_grant;
    logic               written;
    logic               done;

    logic               push;
    logic               pop;
    logic               full;
    logic               empty;
    scaler_pkg::pixel_t fq_p00;
    scaler_pkg::pixel_t fq_p01;
    scaler_pkg::pixel_t fq_p10;
    scaler_pkg::pixel_t fq_p11;
    scaler_pkg::frac_t  fq_fx;
    scaler_pkg::frac_t  fq_fy;
    scaler_pkg::addr_t  fq_addr;
    scaler_pkg::pixel_t hd_p00;
    scaler_pkg::pixel_t hd_p01;
    scaler_pkg::pixel_t hd_p10;
    scaler_pkg::pixel_t hd_p11;
    scaler_pkg::frac_t  hd_fx;
    scaler_pkg::frac_t  hd_fy;
    scaler_pkg::addr_t  hd_addr;

    // ==================================================
    // Pass control
    // ==================================================
    assign w_prod      = {8'd0, in_width} * {8'd0, scale};
    assign h_prod      = {8'd0, in_height} * {8'd0, scale};
    assign pix_total   = {8'd0, out_width} * {8'd0, out_height};
    assign wr_cnt_next = wr_cnt + {15'd0, written};

    // Start is dropped while a pass runs
    assign accept = start && !run;
    assign finish = run && ((pix_total == 16'd0) || (done && wr_cnt_next == pix_total));
    assign busy   = run;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run        <= 1'b0;
            ready      <= 1'b0;
            wr_cnt     <= '0;
            src_width  <= '0;
            src_height <= '0;
            scale_q    <= '0;
            out_width  <= '0;
            out_height <= '0;
            read_count <= '0;
        end else begin
            ready <= finish;
            if (accept) begin
                run        <= 1'b1;
                wr_cnt     <= '0;
                src_width  <= in_width;
                src_height <= in_height;
                scale_q    <= scale;
                out_width  <= w_prod[15:8];
                out_height <= h_prod[15:8];
            end else begin
                wr_cnt <= wr_cnt_next;
                if (finish) begin
                    run <= 1'b0;
                end
            end
            if (rd_grant || ext_read) begin
                read_count <= read_count + 32'd1;
            end
        end
    end

    assign ext_rdata = rdata;

    // ==================================================
    // Blocks
    // ==================================================
    pixel_memory u_mem (
        .clk(clk), .rst(rst),
        .ext_write(ext_write), .ext_read(ext_read),
        .ext_addr(ext_addr), .ext_wdata(ext_wdata),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_grant(wr_grant), .rd_grant(rd_grant), .rdata(rdata)
    );

    quad_fetch u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .in_width(src_width), .in_height(src_height), .scale(scale_q),
        .out_width(out_width), .out_height(out_height),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_grant(rd_grant), .rdata(rdata),
        .full(full), .push(push),
        .q_p00(fq_p00), .q_p01(fq_p01), .q_p10(fq_p10), .q_p11(fq_p11),
        .q_fx(fq_fx), .q_fy(fq_fy), .q_addr(fq_addr), .done(done)
    );

    quad_fifo u_fifo (
        .clk(clk), .rst(rst), .push(push), .pop(pop),
        .push_p00(fq_p00), .push_p01(fq_p01), .push_p10(fq_p10), .push_p11(fq_p11),
        .push_fx(fq_fx), .push_fy(fq_fy), .push_addr(fq_addr),
        .head_p00(hd_p00), .head_p01(hd_p01), .head_p10(hd_p10), .head_p11(hd_p11),
        .head_fx(hd_fx), .head_fy(hd_fy), .head_addr(hd_addr),
        .full(full), .empty(empty)
    );

    bilinear_write u_interp (
        .clk(clk), .rst(rst), .empty(empty), .pop(pop),
        .p00(hd_p00), .p01(hd_p01), .p10(hd_p10), .p11(hd_p11),
        .fx(hd_fx), .fy(hd_fy), .addr(hd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_grant(wr_grant),
        .ext_write(ext_write), .written(written),
        .op_count(op_count), .write_count(write_count)
    );

endmodule

// File: design/bilinear_write.sv
// Bilinear interpolator and writer
// Two registered blend stages per quad, then holds the write until the memory takes it

`include "scaler_params.svh"

module bilinear_write (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    output logic                pop,
    input  scaler_pkg::pixel_t  p00,
    input  scaler_pkg::pixel_t  p01,
    input  scaler_pkg::pixel_t  p10,
    input  scaler_pkg::pixel_t  p11,
    input  scaler_pkg::frac_t   fx,
    input  scaler_pkg::frac_t   fy,
    input  scaler_pkg::addr_t   addr,
    output logic                wr_req,
    output scaler_pkg::addr_t   wr_addr,
    output scaler_pkg::pixel_t  wr_data,
    input  logic                wr_grant,
    input  logic                ext_write,
    output logic                written,
    output scaler_pkg::count_t  op_count,
    output scaler_pkg::count_t  write_count
);

    logic                s1_valid;
    logic [15:0]         top_mix;
    logic [15:0]         bot_mix;
    scaler_pkg::frac_t   fy_s1;
    scaler_pkg::addr_t   addr_s1;
    logic [8:0]          wx;
    logic [8:0]          wy;
    logic [15:0]         h_top;
    logic [15:0]         h_bot;
    logic [24:0]         v_sum;

    // One quad in flight at a time
    assign pop = !empty && !s1_valid && !wr_req;

    // ==================================================
    // Horizontal blend of top and bottom rows
    // ==================================================
    assign wx    = 9'd256 - {1'b0, fx};
    assign h_top = {8'd0, p00} * {7'd0, wx} + {8'd0, p01} * {8'd0, fx};
    assign h_bot = {8'd0, p10} * {7'd0, wx} + {8'd0, p11} * {8'd0, fx};

    // ==================================================
    // Vertical blend into a Q16 result
    // ==================================================
    assign wy    = 9'd256 - {1'b0, fy_s1};
    assign v_sum = {9'd0, top_mix} * {16'd0, wy} + {9'd0, bot_mix} * {17'd0, fy_s1};

    always_ff @(posedge clk) begin
        if (pop) begin
            top_mix <= h_top;
            bot_mix <= h_bot;
            fy_s1   <= fy;
            addr_s1 <= addr;
        end
        if (s1_valid) begin
            wr_data <= v_sum[23:16];
            wr_addr <= addr_s1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            wr_req      <= 1'b0;
            written     <= 1'b0;
            op_count    <= '0;
            write_count <= '0;
        end else begin
            s1_valid <= pop;
            written  <= wr_grant;
            if (s1_valid) begin
                wr_req <= 1'b1;
            end else if (wr_grant) begin
                wr_req <= 1'b0;
            end
            if (wr_grant) begin
                op_count <= op_count + scaler_pkg::count_t'(`SCALER_OPS_PER_PIXEL);
            end
            // External writes are counted here as well
            if (wr_grant || ext_write) begin
                write_count <= write_count + 32'd1;
            end
        end
    end

endmodule

// File: design/quad_fifo.sv
// Quad FIFO
// Circular buffer of fetched neighbour quads with their fractions and output address

`include "scaler_params.svh"

module quad_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  logic               pop,
    input  scaler_pkg::pixel_t push_p00,
    input  scaler_pkg::pixel_t push_p01,
    input  scaler_pkg::pixel_t push_p10,
    input  scaler_pkg::pixel_t push_p11,
    input  scaler_pkg::frac_t  push_fx,
    input  scaler_pkg::frac_t  push_fy,
    input  scaler_pkg::addr_t  push_addr,
    output scaler_pkg::pixel_t head_p00,
    output scaler_pkg::pixel_t head_p01,
    output scaler_pkg::pixel_t head_p10,
    output scaler_pkg::pixel_t head_p11,
    output scaler_pkg::frac_t  head_fx,
    output scaler_pkg::frac_t  head_fy,
    output scaler_pkg::addr_t  head_addr,
    output logic               full,
    output logic               empty
);

    localparam int DEPTH   = `SCALER_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int ENTRY_W = 6 * 8 + `SCALER_ADDR_W;

    logic [ENTRY_W-1:0] slots [0:DEPTH-1];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (PTR_W + 1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head entry is visible without a read cycle
    assign {head_p00, head_p01, head_p10, head_p11, head_fx, head_fy, head_addr} = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= {push_p00, push_p01, push_p10, push_p11,
                              push_fx, push_fy, push_addr};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

endmodule

// File: design/quad_fetch.sv
// Quad fetch
// Walks the output raster, maps each pixel into the source through the Q8.8
// reciprocal and reads the four clamped neighbours for the interpolator

`include "scaler_params.svh"

module quad_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  scaler_pkg::dim_t   in_width,
    input  scaler_pkg::dim_t   in_height,
    input  scaler_pkg::scale_t scale,
    input  scaler_pkg::dim_t   out_width,
    input  scaler_pkg::dim_t   out_height,
    output logic               rd_req,
    output scaler_pkg::addr_t  rd_addr,
    input  logic               rd_grant,
    input  scaler_pkg::pixel_t rdata,
    input  logic               full,
    output logic               push,
    output scaler_pkg::pixel_t q_p00,
    output scaler_pkg::pixel_t q_p01,
    output scaler_pkg::pixel_t q_p10,
    output scaler_pkg::pixel_t q_p11,
    output scaler_pkg::frac_t  q_fx,
    output scaler_pkg::frac_t  q_fy,
    output scaler_pkg::addr_t  q_addr,
    output logic               done
);

    scaler_pkg::fetch_state_t state;
    scaler_pkg::dim_t         x;
    scaler_pkg::dim_t         y;
    scaler_pkg::dim_t         x0;
    scaler_pkg::dim_t         x1;
    scaler_pkg::dim_t         y0;
    scaler_pkg::dim_t         y1;
    scaler_pkg::frac_t        fx;
    scaler_pkg::frac_t        fy;
    scaler_pkg::pixel_t       quad [0:3];
    logic [1:0]               idx;
    logic [1:0]               pend_idx;
    logic                     pend;

    logic [16:0]              inv;
    logic [24:0]              map_x;
    logic [24:0]              map_y;
    scaler_pkg::dim_t         nx;
    scaler_pkg::dim_t         ny;
    scaler_pkg::dim_t         row;
    scaler_pkg::dim_t         col;
    logic [15:0]              src_off;
    logic [15:0]              dst_off;
    logic                     last_x;
    logic                     last_y;

    // ==================================================
    // Coordinate mapping
    // ==================================================
    assign inv   = (scale == 8'd0) ? 17'd256 : 17'h10000 / {9'd0, scale};
    assign map_x = {17'd0, x} * {8'd0, inv};
    assign map_y = {17'd0, y} * {8'd0, inv};

    // Right and bottom neighbours stop at the last column and row
    assign nx = (map_x[15:8] >= in_width - 8'd1) ? in_width - 8'd1 : map_x[15:8] + 8'd1;
    assign ny = (map_y[15:8] >= in_height - 8'd1) ? in_height - 8'd1 : map_y[15:8] + 8'd1;

    // idx bit 0 picks the column, bit 1 the row
    assign row     = idx[1] ? y1 : y0;
    assign col     = idx[0] ? x1 : x0;
    assign src_off = {8'd0, row} * {8'd0, in_width} + {8'd0, col};
    assign dst_off = {8'd0, y} * {8'd0, out_width} + {8'd0, x};

    assign last_x = (x == out_width - 8'd1);
    assign last_y = (y == out_height - 8'd1);

    assign rd_req  = (state == scaler_pkg::READ);
    assign rd_addr = scaler_pkg::addr_t'(src_off);
    assign push    = (state == scaler_pkg::PUSH) && !full;
    assign done    = (state == scaler_pkg::DONE);

    // Last byte may still be on rdata in the first PUSH cycle
    assign q_p00  = quad[0];
    assign q_p01  = quad[1];
    assign q_p10  = quad[2];
    assign q_p11  = pend ? rdata : quad[3];
    assign q_fx   = fx;
    assign q_fy   = fy;
    assign q_addr = scaler_pkg::addr_t'(`SCALER_OUT_BASE + dst_off);

    // ==================================================
    // Raster FSM
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= scaler_pkg::IDLE;
            x     <= '0;
            y     <= '0;
            idx   <= '0;
            pend  <= 1'b0;
        end else begin
            pend <= rd_grant;
            case (state)
                scaler_pkg::IDLE: begin
                    if (run) begin
                        x <= '0;
                        y <= '0;
                        if (out_width == 8'd0 || out_height == 8'd0) begin
                            state <= scaler_pkg::DONE;
                        end else begin
                            state <= scaler_pkg::MAP;
                        end
                    end
                end
                scaler_pkg::MAP: begin
                    idx   <= '0;
                    state <= scaler_pkg::READ;
                end
                scaler_pkg::READ: begin
                    if (rd_grant) begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd3) begin
                            state <= scaler_pkg::PUSH;
                        end
                    end
                end
                scaler_pkg::PUSH: begin
                    if (!full) begin
                        if (!last_x) begin
                            x     <= x + 8'd1;
                            state <= scaler_pkg::MAP;
                        end else if (!last_y) begin
                            x     <= '0;
                            y     <= y + 8'd1;
                            state <= scaler_pkg::MAP;
                        end else begin
                            state <= scaler_pkg::DONE;
                        end
                    end
                end
                scaler_pkg::DONE: begin
                    if (!run) begin
                        state <= scaler_pkg::IDLE;
                    end
                end
                default: state <= scaler_pkg::IDLE;
            endcase
        end
    end

    // Neighbour coordinates, fractions and fetched bytes
    always_ff @(posedge clk) begin
        if (state == scaler_pkg::MAP) begin
            x0 <= map_x[15:8];
            y0 <= map_y[15:8];
            x1 <= nx;
            y1 <= ny;
            fx <= map_x[7:0];
            fy <= map_y[7:0];
        end
        if (rd_grant) begin
            pend_idx <= idx;
        end
        if (pend) begin
            quad[pend_idx] <= rdata;
        end
    end

endmodule

// File: design/pixel_memory.sv
// Shared pixel memory
// Single-port byte array; external access beats engine write, which beats engine read

`include "scaler_params.svh"

module pixel_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               ext_write,
    input  logic               ext_read,
    input  scaler_pkg::addr_t  ext_addr,
    input  scaler_pkg::pixel_t ext_wdata,
    input  logic               wr_req,
    input  scaler_pkg::addr_t  wr_addr,
    input  scaler_pkg::pixel_t wr_data,
    input  logic               rd_req,
    input  scaler_pkg::addr_t  rd_addr,
    output logic               wr_grant,
    output logic               rd_grant,
    output scaler_pkg::pixel_t rdata
);

    scaler_pkg::pixel_t mem [0:`SCALER_MEM_DEPTH-1];
    logic               ext_active;

    // External port first, then engine write, then engine read
    assign ext_active = ext_write || ext_read;
    assign wr_grant   = wr_req && !ext_active;
    assign rd_grant   = rd_req && !ext_active && !wr_req;

    always_ff @(posedge clk) begin
        if (ext_write) begin
            mem[ext_addr] <= ext_wdata;
        end else if (wr_grant) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lands one cycle after the access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (ext_read) begin
            rdata <= mem[ext_addr];
        end else if (rd_grant) begin
            rdata <= mem[rd_addr];
        end
    end

endmodule

// File: design/scaler_pkg.sv
// Scaler types
// Vector typedefs for addresses, samples and coordinates, plus the fetch FSM states

`include "scaler_params.svh"

package scaler_pkg;

    // Byte address into the shared memory
    typedef logic [`SCALER_ADDR_W-1:0] addr_t;

    // One grey sample
    typedef logic [7:0] pixel_t;

    // Image dimension or coordinate
    typedef logic [7:0] dim_t;

    // Unsigned Q0.8 scale factor
    typedef logic [7:0] scale_t;

    // Interpolation weight as value/256
    typedef logic [7:0] frac_t;

    // Performance counter
    typedef logic [31:0] count_t;

    // Producer FSM
    typedef enum logic [2:0] {
        IDLE,
        MAP,
        READ,
        PUSH,
        DONE
    } fetch_state_t;

endpackage

// File: design/scaler_params.svh
// Scaler build constants
// Memory geometry, output image base, FIFO depth and operation accounting

`ifndef SCALER_PARAMS_SVH
`define SCALER_PARAMS_SVH

// Shared byte memory
`define SCALER_ADDR_W        12
`define SCALER_MEM_DEPTH     4096

// Output image starts half way up the memory
`define SCALER_OUT_BASE      2048

// Quad buffer between fetch and interpolation
`define SCALER_FIFO_DEPTH    4

// Multiplies and adds charged per interpolated pixel
`define SCALER_OPS_PER_PIXEL 8

`endif
